/* logic/cmd_ram_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_ram_reader (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic                               byte_req,
	output logic [host_pkg::RAM_ADDR_BITS-1:0] ram_ra,
	input  logic [7:0]                         ram_rd,
	output host_pkg::cmd_hdr_t                 hdr,
	output logic                               hdr_valid,
	output logic [7:0]                         page_byte
);

	typedef logic [host_pkg::RAM_ADDR_BITS-1:0] ra_t;

	// header fetch: address side and data side, one cycle apart
	logic       fetch_on;
	logic [2:0] fetch_idx;
	logic       rd_v;
	logic [2:0] rd_idx;
	// page byte index, wraps each page
	logic [$clog2(flash_cmd_pkg::PAGE_BYTES)-1:0] pidx;
	logic pv1;
	logic pv2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_on  <= 1'b0;
			fetch_idx <= '0;
			rd_v      <= 1'b0;
			rd_idx    <= '0;
			pidx      <= '0;
			pv1       <= 1'b0;
			pv2       <= 1'b0;
			hdr_valid <= 1'b0;
			ram_ra    <= '0;
		end else begin
			rd_v      <= fetch_on;
			rd_idx    <= fetch_idx;
			pv1       <= byte_req;
			pv2       <= pv1;
			// last header byte lands on this edge
			hdr_valid <= rd_v && (rd_idx == 3'(host_pkg::HDR_BYTES - 1));
			if (start && !fetch_on) begin
				fetch_on  <= 1'b1;
				fetch_idx <= '0;
				ram_ra    <= '0;
				pidx      <= '0;
			end else if (fetch_on) begin
				if (fetch_idx == 3'(host_pkg::HDR_BYTES - 1)) begin
					fetch_on <= 1'b0;
				end else begin
					fetch_idx <= fetch_idx + 3'd1;
					ram_ra    <= ra_t'(fetch_idx + 3'd1);
				end
			end else if (byte_req) begin
				ram_ra <= ra_t'(host_pkg::DATA_BASE) + ra_t'(pidx);
				pidx   <= pidx + 1'b1;
			end
		end
	end

	// header fields, high address byte first
	always_ff @(posedge clk) begin
		if (rd_v) begin
			case (rd_idx)
				3'd0: hdr.cmd                <= ram_rd[3:0];
				3'd1: hdr.pages              <= ram_rd;
				3'd2: hdr.last_sector        <= ram_rd;
				3'd3: hdr.base_addr[23:16]   <= ram_rd;
				3'd4: hdr.base_addr[15:8]    <= ram_rd;
				default: hdr.base_addr[7:0]  <= ram_rd;
			endcase
		end
	end

	// held until the engine loads it
	always_ff @(posedge clk) begin
		if (pv2) begin
			page_byte <= ram_rd;
		end
	end

endmodule

`default_nettype wire

/* logic/flash_cmd_pkg.sv */
`default_nettype none

// serial NOR flash side: opcodes, instruction codes, frame timing
package flash_cmd_pkg;

	// instruction carried by one frame
	typedef enum logic [2:0] {
		IDLE,
		WREN,
		RDSR,
		SE,
		PP
	} flash_instr_t;

	localparam logic [7:0] OPC_WREN = 8'h06;
	localparam logic [7:0] OPC_RDSR = 8'h05;
	// 64 KiB sector erase
	localparam logic [7:0] OPC_SE   = 8'hD8;
	localparam logic [7:0] OPC_PP   = 8'h02;

	// deselect time: 25 MHz clock, 100 ns tSHSL, rounded up
	localparam int FCLK_MHZ           = 25;
	localparam int T_SHSL_NS          = 100;
	localparam int CS_DESELECT_CYCLES = (FCLK_MHZ * T_SHSL_NS + 999) / 1000;

	localparam int ADDR_BITS    = 24;
	localparam int PAGE_BYTES   = 256;
	localparam int SECTOR_SHIFT = 16;

	// status register bits
	localparam int SR_WIP = 0;
	localparam int SR_WEL = 1;

	// one frame request, go is a single-cycle pulse
	// poll_wel: 1 waits for WEL set, 0 waits for WIP clear
	typedef struct packed {
		logic                 go;
		flash_instr_t         instr;
		logic [ADDR_BITS-1:0] addr;
		logic                 poll_wel;
	} flash_req_t;

endpackage

`default_nettype wire

/* logic/flash_ctrl_s25fl.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_ctrl_s25fl (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic                               page_ready,
	output logic [host_pkg::RAM_ADDR_BITS-1:0] ram_ra,
	input  logic [7:0]                         ram_rd,
	output logic                               cs_en,
	output logic                               sck_en,
	output logic                               sdo,
	input  logic                               sdi,
	output logic                               tx_v,
	output logic [7:0]                         tx_d,
	output logic                               busy
);

	host_pkg::cmd_hdr_t                  hdr;
	logic                                hdr_valid;
	logic                                byte_req;
	logic [7:0]                          page_byte;
	flash_cmd_pkg::flash_req_t           req;
	logic                                frame_done;
	logic [7:0]                          status;
	logic                                done;
	logic [flash_cmd_pkg::ADDR_BITS-1:0] cur_addr;
	logic                                busy_seq;
	logic                                busy_rpt;

	assign busy = busy_seq | busy_rpt;

	// start only counts while idle
	cmd_ram_reader cmd_ram_reader_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start & ~busy),
		.byte_req  (byte_req),
		.ram_ra    (ram_ra),
		.ram_rd    (ram_rd),
		.hdr       (hdr),
		.hdr_valid (hdr_valid),
		.page_byte (page_byte)
	);

	flash_sequencer flash_sequencer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.hdr        (hdr),
		.hdr_valid  (hdr_valid),
		.page_ready (page_ready),
		.frame_done (frame_done),
		.req        (req),
		.done       (done),
		.cur_addr   (cur_addr),
		.busy       (busy_seq)
	);

	spi_frame_engine spi_frame_engine_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.page_byte  (page_byte),
		.byte_req   (byte_req),
		.cs_en      (cs_en),
		.sck_en     (sck_en),
		.sdo        (sdo),
		.sdi        (sdi),
		.frame_done (frame_done),
		.status     (status)
	);

	result_reporter result_reporter_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.done     (done),
		.hdr      (hdr),
		.cur_addr (cur_addr),
		.status   (status),
		.tx_v     (tx_v),
		.tx_d     (tx_d),
		.busy_rpt (busy_rpt)
	);

endmodule

`default_nettype wire

/* logic/flash_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_sequencer (
	input  logic                                clk,
	input  logic                                rst_n,
	input  host_pkg::cmd_hdr_t                  hdr,
	input  logic                                hdr_valid,
	input  logic                                page_ready,
	input  logic                                frame_done,
	output flash_cmd_pkg::flash_req_t           req,
	output logic                                done,
	output logic [flash_cmd_pkg::ADDR_BITS-1:0] cur_addr,
	output logic                                busy
);

	typedef logic [flash_cmd_pkg::ADDR_BITS-1:0] addr_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT,
		S_PAGE,
		S_DONE
	} seq_state_t;

	seq_state_t state;
	// step in a group: WREN, RDSR(WEL), SE or PP, RDSR(WIP)
	logic [1:0] step;
	// 0 while erasing, 1 while programming
	logic       prog;
	logic       pick;
	logic [7:0] sect;
	logic [7:0] page;
	// page_ready seen but not yet used
	logic       page_pend;
	addr_t      se_addr;
	addr_t      pp_addr;

	assign se_addr = hdr.base_addr + (addr_t'(sect) << flash_cmd_pkg::SECTOR_SHIFT);
	assign pp_addr = hdr.base_addr + (addr_t'(page) << $clog2(flash_cmd_pkg::PAGE_BYTES));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			req       <= '0;
			done      <= 1'b0;
			busy      <= 1'b0;
			cur_addr  <= '0;
			step      <= '0;
			prog      <= 1'b0;
			pick      <= 1'b0;
			sect      <= '0;
			page      <= '0;
			page_pend <= 1'b0;
		end else begin
			req.go <= 1'b0;
			done   <= 1'b0;
			if (page_ready) begin
				page_pend <= 1'b1;
			end
			case (state)
				S_IDLE: begin
					if (hdr_valid) begin
						busy      <= 1'b1;
						step      <= '0;
						prog      <= 1'b0;
						sect      <= '0;
						page      <= '0;
						page_pend <= 1'b0;
						pick      <= (hdr.cmd == host_pkg::CMD_PICKUP);
						if (hdr.cmd == host_pkg::CMD_UPDATE || hdr.cmd == host_pkg::CMD_PICKUP) begin
							state <= S_ISSUE;
						end else begin
							// unknown command, report straight away
							done  <= 1'b1;
							state <= S_DONE;
						end
					end
				end
				S_ISSUE: begin
					req.go       <= 1'b1;
					req.poll_wel <= 1'b0;
					state        <= S_WAIT;
					if (pick) begin
						req.instr <= flash_cmd_pkg::RDSR;
					end else begin
						case (step)
							2'd0: req.instr <= flash_cmd_pkg::WREN;
							2'd1: begin
								req.instr    <= flash_cmd_pkg::RDSR;
								req.poll_wel <= 1'b1;
							end
							2'd2: begin
								req.instr <= prog ? flash_cmd_pkg::PP : flash_cmd_pkg::SE;
								req.addr  <= prog ? pp_addr : se_addr;
								cur_addr  <= prog ? pp_addr : se_addr;
							end
							default: req.instr <= flash_cmd_pkg::RDSR;
						endcase
					end
				end
				S_WAIT: begin
					if (frame_done) begin
						if (pick) begin
							done  <= 1'b1;
							state <= S_DONE;
						end else if (step != 2'd3) begin
							step  <= step + 2'd1;
							state <= S_ISSUE;
						end else begin
							step <= '0;
							// next sector, last page, or next page
							if (!prog && sect != hdr.last_sector) begin
								sect  <= sect + 8'd1;
								state <= S_ISSUE;
							end else if (prog ? (page == hdr.pages - 8'd1) : (hdr.pages == 8'd0)) begin
								done  <= 1'b1;
								state <= S_DONE;
							end else begin
								if (prog) begin
									page <= page + 8'd1;
								end
								prog  <= 1'b1;
								state <= S_PAGE;
							end
						end
					end
				end
				S_PAGE: begin
					// host pulse gates every page
					if (page_pend || page_ready) begin
						page_pend <= 1'b0;
						state     <= S_ISSUE;
					end
				end
				default: begin
					// done cycle, reporter takes over busy
					busy  <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/host_pkg.sv */
`default_nettype none

// host side: command block in the byte RAM and the returned report
package host_pkg;

	// command codes, low nibble of RAM byte 0
	localparam logic [3:0] CMD_UPDATE = 4'd1;
	localparam logic [3:0] CMD_PICKUP = 4'd6;

	// header in RAM
	//   0: cmd in [3:0], upper nibble ignored
	//   1: pages to program
	//   2: last_sector (sector count minus one)
	//   3..5: base_addr, high byte first
	//   6..7: reserved
	localparam int HDR_BYTES     = 6;
	// page data starts here, 256 bytes reused for every page
	localparam int DATA_BASE     = 8;
	localparam int RAM_ADDR_BITS = 9;

	typedef struct packed {
		logic [3:0]                          cmd;
		logic [7:0]                          pages;
		logic [7:0]                          last_sector;
		logic [flash_cmd_pkg::ADDR_BITS-1:0] base_addr;
	} cmd_hdr_t;

	// update report, one byte per tx_v
	//   0: {RPT_STATUS_DONE, cmd}   1: 0   2: last_sector
	//   3..5: final flash address, high byte first   6..7: 0
	localparam int         RPT_BYTES       = 8;
	localparam logic [3:0] RPT_STATUS_DONE = 4'b0100;

endpackage

`default_nettype wire

/* logic/result_reporter.sv */
`timescale 1ns/1ps
`default_nettype none

module result_reporter (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                done,
	input  host_pkg::cmd_hdr_t                  hdr,
	input  logic [flash_cmd_pkg::ADDR_BITS-1:0] cur_addr,
	input  logic [7:0]                          status,
	output logic                                tx_v,
	output logic [7:0]                          tx_d,
	output logic                                busy_rpt
);

	logic [$clog2(host_pkg::RPT_BYTES)-1:0] idx;
	logic [$clog2(host_pkg::RPT_BYTES)-1:0] nxt_idx;
	// pickup sends only the status byte
	logic single;
	logic pickup;

	assign pickup  = (hdr.cmd == host_pkg::CMD_PICKUP);
	assign nxt_idx = idx + 1'b1;

	// update report layout
	function automatic logic [7:0] rpt_byte(input logic [$clog2(host_pkg::RPT_BYTES)-1:0] i);
		case (i)
			3'd0:    return {host_pkg::RPT_STATUS_DONE, hdr.cmd};
			3'd2:    return hdr.last_sector;
			3'd3:    return cur_addr[23:16];
			3'd4:    return cur_addr[15:8];
			3'd5:    return cur_addr[7:0];
			default: return 8'h00;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_v     <= 1'b0;
			busy_rpt <= 1'b0;
			single   <= 1'b0;
			idx      <= '0;
		end else if (done) begin
			tx_v     <= 1'b1;
			busy_rpt <= 1'b1;
			single   <= pickup;
			idx      <= '0;
		end else if (tx_v) begin
			// busy drops on the same edge as the last byte
			if (single || idx == ($bits(idx))'(host_pkg::RPT_BYTES - 1)) begin
				tx_v     <= 1'b0;
				busy_rpt <= 1'b0;
			end else begin
				idx <= nxt_idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			tx_d <= pickup ? status : rpt_byte('0);
		end else if (tx_v) begin
			tx_d <= rpt_byte(nxt_idx);
		end
	end

endmodule

`default_nettype wire

/* logic/spi_frame_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_engine (
	input  logic                      clk,
	input  logic                      rst_n,
	input  flash_cmd_pkg::flash_req_t req,
	input  logic [7:0]                page_byte,
	output logic                      byte_req,
	output logic                      cs_en,
	output logic                      sck_en,
	output logic                      sdo,
	input  logic                      sdi,
	output logic                      frame_done,
	output logic [7:0]                status
);

	typedef enum logic [2:0] {
		E_IDLE,
		E_CMD,
		E_DATA,
		E_POLL,
		E_DESEL
	} eng_state_t;

	eng_state_t                 st;
	flash_cmd_pkg::flash_instr_t instr;
	logic                       poll_wel;
	// opcode then address, MSB leaves first
	logic [31:0]                sh;
	// bits left in the current field, minus one
	logic [4:0]                 bit_cnt;
	logic [7:0]                 byte_cnt;
	logic [6:0]                 rx;
	logic [7:0]                 rx_byte;
	logic                       poll_met;
	logic [$clog2(flash_cmd_pkg::CS_DESELECT_CYCLES + 1)-1:0] dcnt;

	function automatic logic [7:0] opcode(input flash_cmd_pkg::flash_instr_t i);
		case (i)
			flash_cmd_pkg::WREN: return flash_cmd_pkg::OPC_WREN;
			flash_cmd_pkg::SE:   return flash_cmd_pkg::OPC_SE;
			flash_cmd_pkg::PP:   return flash_cmd_pkg::OPC_PP;
			default:             return flash_cmd_pkg::OPC_RDSR;
		endcase
	endfunction

	assign sdo = sh[31];
	// flash drives status right after the last opcode bit
	assign rx_byte  = {rx, sdi};
	assign poll_met = poll_wel ? rx_byte[flash_cmd_pkg::SR_WEL] : !rx_byte[flash_cmd_pkg::SR_WIP];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st         <= E_IDLE;
			cs_en      <= 1'b0;
			sck_en     <= 1'b0;
			byte_req   <= 1'b0;
			frame_done <= 1'b0;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			dcnt       <= '0;
		end else begin
			byte_req   <= 1'b0;
			frame_done <= 1'b0;
			case (st)
				E_IDLE: begin
					if (req.go) begin
						cs_en    <= 1'b1;
						sck_en   <= 1'b1;
						instr    <= req.instr;
						poll_wel <= req.poll_wel;
						sh       <= {opcode(req.instr), req.addr};
						st       <= E_CMD;
						// address only for SE and PP
						if (req.instr == flash_cmd_pkg::SE || req.instr == flash_cmd_pkg::PP) begin
							bit_cnt <= 5'd31;
						end else begin
							bit_cnt <= 5'd7;
						end
						// first page byte well ahead of use
						byte_req <= (req.instr == flash_cmd_pkg::PP);
					end
				end
				E_CMD: begin
					sh      <= sh << 1;
					bit_cnt <= bit_cnt - 5'd1;
					if (bit_cnt == 5'd0) begin
						bit_cnt <= 5'd7;
						if (instr == flash_cmd_pkg::PP) begin
							sh       <= {page_byte, 24'h0};
							byte_cnt <= '0;
							byte_req <= 1'b1;
							st       <= E_DATA;
						end else if (instr == flash_cmd_pkg::RDSR) begin
							st <= E_POLL;
						end else begin
							cs_en  <= 1'b0;
							sck_en <= 1'b0;
							dcnt   <= '0;
							st     <= E_DESEL;
						end
					end
				end
				E_DATA: begin
					sh      <= sh << 1;
					bit_cnt <= bit_cnt - 5'd1;
					if (bit_cnt == 5'd0) begin
						if (byte_cnt == 8'(flash_cmd_pkg::PAGE_BYTES - 1)) begin
							cs_en  <= 1'b0;
							sck_en <= 1'b0;
							dcnt   <= '0;
							st     <= E_DESEL;
						end else begin
							sh       <= {page_byte, 24'h0};
							bit_cnt  <= 5'd7;
							byte_cnt <= byte_cnt + 8'd1;
							// no request past the last byte
							byte_req <= (byte_cnt != 8'(flash_cmd_pkg::PAGE_BYTES - 2));
						end
					end
				end
				E_POLL: begin
					rx      <= rx_byte[6:0];
					bit_cnt <= bit_cnt - 5'd1;
					if (bit_cnt == 5'd0) begin
						status  <= rx_byte;
						bit_cnt <= 5'd7;
						// chip select held until a byte meets the condition
						if (poll_met) begin
							cs_en  <= 1'b0;
							sck_en <= 1'b0;
							dcnt   <= '0;
							st     <= E_DESEL;
						end
					end
				end
				default: begin
					if (dcnt == ($bits(dcnt))'(flash_cmd_pkg::CS_DESELECT_CYCLES - 1)) begin
						frame_done <= 1'b1;
						st         <= E_IDLE;
					end else begin
						dcnt <= dcnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_flash_ctrl -f vlog.f \
	> build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vtb_flash_ctrl > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log && exit 0
exit 1

/* tb/flash_ctrl_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// frame and result rules on the DUT pins
module flash_ctrl_sva (
	input logic clk,
	input logic rst_n,
	input logic cs_en,
	input logic sck_en,
	input logic tx_v
);

	// low cycles of chip select, saturating
	logic [3:0] low_cnt;
	// failed assertions so far
	int         fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			low_cnt <= 4'hF;
		end else if (cs_en) begin
			low_cnt <= 4'h0;
		end else if (low_cnt != 4'hF) begin
			low_cnt <= low_cnt + 4'd1;
		end
	end

	// clock enable only inside a frame
	sck_inside_frame: assert property (@(posedge clk) disable iff (!rst_n) sck_en |-> cs_en)
		else begin
			$error("sck_en high while cs_en is low");
			fail_cnt++;
		end

	// deselect time before every new frame
	deselect_time: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cs_en) |-> low_cnt >= 4'(flash_cmd_pkg::CS_DESELECT_CYCLES))
		else begin
			$error("cs_en low for fewer than the deselect cycles");
			fail_cnt++;
		end

	// results only once the flash is idle
	tx_outside_frame: assert property (@(posedge clk) disable iff (!rst_n) tx_v |-> !cs_en)
		else begin
			$error("tx_v high during a frame");
			fail_cnt++;
		end

endmodule

bind flash_ctrl_s25fl flash_ctrl_sva flash_ctrl_sva_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.cs_en  (cs_en),
	.sck_en (sck_en),
	.tx_v   (tx_v)
);

`default_nettype wire

/* tb/spi_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

// serial NOR flash, one bit per controller clock while cs_en and sck_en are high
module spi_flash_model (
	input  logic clk,
	input  logic cs_en,
	input  logic sck_en,
	input  logic sdo,
	output logic sdi
);

	// programmed bytes only, keyed by flash address
	logic [7:0]  mem [logic [23:0]];
	logic        erased [0:255] = '{default: 1'b0};
	logic [23:0] se_addr [0:7];
	logic        wel = 1'b0;
	logic        wip = 1'b0;
	logic        miso = 1'b0;
	logic [7:0]  opc = 8'h00;
	logic [23:0] addr = 24'h0;
	logic [7:0]  dbyte = 8'h00;
	// status byte being shifted out
	logic [7:0]  sr_sh = 8'h00;
	int          nbits = 0;
	int          rd_idx = 0;
	int          busy_cnt = 0;
	int          se_cnt = 0;
	int          pp_cnt = 0;
	int          err_cnt = 0;

	assign sdi = miso;

	always @(posedge clk) begin
		// write or erase in progress
		if (busy_cnt != 0) begin
			busy_cnt = busy_cnt - 1;
			if (busy_cnt == 0) begin
				wip = 1'b0;
			end
		end
		if (cs_en && sck_en) begin
			if (nbits < 8) begin
				opc = {opc[6:0], sdo};
				if (nbits == 7) begin
					if ((opc == flash_cmd_pkg::OPC_SE || opc == flash_cmd_pkg::OPC_PP) && wip) begin
						err_cnt++;
						$display("flash model: SE or PP opcode received while WIP is set");
					end
					if (opc == flash_cmd_pkg::OPC_PP) begin
						pp_cnt++;
					end
					// status MSB goes out right after the opcode
					if (opc == flash_cmd_pkg::OPC_RDSR) begin
						sr_sh = {6'h07, wel, wip};
						miso <= sr_sh[7];
						rd_idx = 1;
					end
				end
			end else if (opc == flash_cmd_pkg::OPC_RDSR) begin
				// fresh status snapshot every byte
				if (rd_idx == 8) begin
					sr_sh = {6'h07, wel, wip};
					rd_idx = 0;
				end
				miso <= sr_sh[7 - rd_idx];
				rd_idx++;
			end else if (nbits < 32) begin
				addr = {addr[22:0], sdo};
			end else begin
				dbyte = {dbyte[6:0], sdo};
				// page offset wraps inside the page
				if (nbits % 8 == 7) begin
					mem[{addr[23:8], addr[7:0] + 8'((nbits - 32) / 8)}] = dbyte;
				end
			end
			nbits++;
		end else if (nbits != 0) begin
			// chip select high, instruction executes
			case (opc)
				flash_cmd_pkg::OPC_WREN: wel = 1'b1;
				flash_cmd_pkg::OPC_RDSR: ;
				flash_cmd_pkg::OPC_SE: begin
					if (!wel || nbits != 32) begin
						err_cnt++;
						$display("flash model: SE without WEL or with a bad frame length");
					end
					erased[addr[23:16]] = 1'b1;
					if (se_cnt < 8) begin
						se_addr[se_cnt] = addr;
					end
					se_cnt++;
					wel = 1'b0;
					wip = 1'b1;
					busy_cnt = 40;
				end
				flash_cmd_pkg::OPC_PP: begin
					if (!wel || !erased[addr[23:16]] || nbits != 32 + 8 * 256) begin
						err_cnt++;
						$display("flash model: PP without WEL, to an unerased sector, or cut short");
					end
					wel = 1'b0;
					wip = 1'b1;
					busy_cnt = 40;
				end
				default: begin
					err_cnt++;
					$display("flash model: unknown opcode %h", opc);
				end
			endcase
			nbits = 0;
			miso <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_flash_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flash_ctrl;

	logic       clk;
	logic       rst_n;
	logic       start;
	logic       page_ready;
	logic [8:0] ram_ra;
	logic [7:0] ram_rd = 8'h00;
	logic       cs_en;
	logic       sck_en;
	logic       sdo;
	logic       sdi;
	logic       tx_v;
	logic [7:0] tx_d;
	logic       busy;

	// command block RAM, registered read
	logic [7:0] ram [0:511];
	integer     seed;
	int         errors;
	int         checks;
	int         pages_sent;
	logic       early_pp = 1'b0;
	logic [7:0] rx_bytes [0:15];
	int         rx_count;

	flash_ctrl_s25fl flash_ctrl_s25fl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.page_ready (page_ready),
		.ram_ra     (ram_ra),
		.ram_rd     (ram_rd),
		.cs_en      (cs_en),
		.sck_en     (sck_en),
		.sdo        (sdo),
		.sdi        (sdi),
		.tx_v       (tx_v),
		.tx_d       (tx_d),
		.busy       (busy)
	);

	spi_flash_model flash_i (
		.clk    (clk),
		.cs_en  (cs_en),
		.sck_en (sck_en),
		.sdo    (sdo),
		.sdi    (sdi)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		ram_rd <= ram[ram_ra];
	end

	// a PP opcode may only follow its page_ready pulse
	always @(negedge clk) begin
		if (!early_pp && flash_i.pp_cnt > pages_sent) begin
			early_pp = 1'b1;
			$display("PP frame started before its page_ready pulse");
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#2 start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
	endtask

	task automatic send_page_ready();
		@(posedge clk);
		#2 page_ready = 1'b1;
		pages_sent++;
		@(posedge clk);
		#2 page_ready = 1'b0;
	endtask

	// gathers one burst of tx_v bytes
	task automatic collect_tx(output bit ok);
		int n;
		ok = 1'b0;
		rx_count = 0;
		for (n = 0; n < 20000; n++) begin
			@(negedge clk);
			if (tx_v) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			errors++;
			$display("timeout: the DUT sent no tx_v byte");
			return;
		end
		while (tx_v && rx_count < 16) begin
			rx_bytes[rx_count] = tx_d;
			rx_count++;
			@(negedge clk);
		end
	endtask

	// given erases and programs executed, WIP poll finished, chip deselected
	task automatic wait_flash_idle(input int se_count, input int pp_count, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < 20000; n++) begin
			@(negedge clk);
			if (flash_i.se_cnt == se_count && flash_i.pp_cnt == pp_count &&
				!flash_i.wip && !cs_en && flash_i.nbits == 0) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			errors++;
			$display("timeout: the flash did not return to idle");
		end
	endtask

	// page_ready held back, no frame may start meanwhile
	task automatic expect_no_frame(input int cycles);
		int n;
		for (n = 0; n < cycles && !cs_en; n++) begin
			@(negedge clk);
		end
		compare_value("cs_en", cs_en, 1'b0);
	endtask

	task automatic wait_pp_started(input int count, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < 20000; n++) begin
			@(negedge clk);
			if (flash_i.pp_cnt >= count) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			errors++;
			$display("timeout: no page program frame after page_ready");
		end
	endtask

	task automatic check_reset_values();
		@(negedge clk);
		compare_value("cs_en", cs_en, 1'b0);
		compare_value("sck_en", sck_en, 1'b0);
		compare_value("tx_v", tx_v, 1'b0);
		compare_value("busy", busy, 1'b0);
	endtask

	task automatic run_status_pickup();
		bit ok;
		ram[0] = {4'h0, host_pkg::CMD_PICKUP};
		pulse_start();
		collect_tx(ok);
		if (!ok) begin
			return;
		end
		compare_value("tx_v count", rx_count, 1);
		// preset bits, WEL clear, WIP clear
		compare_value("tx_d", rx_bytes[0], {6'h07, 1'b0, 1'b0});
		compare_value("busy", busy, 1'b0);
	endtask

	task automatic run_image_update();
		bit          ok;
		logic [23:0] base;
		logic [23:0] last;
		logic [23:0] a;
		logic [7:0]  exp [0:7];
		int          i;
		int          p;
		base = 24'h12_0000;
		// two pages, two sectors
		ram[0] = {4'h0, host_pkg::CMD_UPDATE};
		ram[1] = 8'd2;
		ram[2] = 8'd1;
		ram[3] = base[23:16];
		ram[4] = base[15:8];
		ram[5] = base[7:0];
		pulse_start();
		wait_flash_idle(2, 0, ok);
		if (!ok) begin
			return;
		end
		compare_value("se_addr[0]", flash_i.se_addr[0], base);
		compare_value("se_addr[1]", flash_i.se_addr[1], base + 24'h01_0000);
		compare_value("pp_cnt", flash_i.pp_cnt, 0);
		for (p = 0; p < 2; p++) begin
			// previous page fully written before the next pulse
			if (p != 0) begin
				wait_flash_idle(2, p, ok);
				if (!ok) begin
					return;
				end
			end
			expect_no_frame(64);
			send_page_ready();
			wait_pp_started(p + 1, ok);
			if (!ok) begin
				return;
			end
		end
		collect_tx(ok);
		if (!ok) begin
			return;
		end
		// last page programmed sits one page above base
		last = base + 24'd256;
		exp[0] = {4'b0100, host_pkg::CMD_UPDATE};
		exp[1] = 8'h00;
		exp[2] = 8'd1;
		exp[3] = last[23:16];
		exp[4] = last[15:8];
		exp[5] = last[7:0];
		exp[6] = 8'h00;
		exp[7] = 8'h00;
		compare_value("tx_v count", rx_count, 8);
		for (i = 0; i < 8; i++) begin
			compare_value($sformatf("tx_d byte %0d", i), rx_bytes[i], exp[i]);
		end
		compare_value("busy", busy, 1'b0);
		compare_value("se_cnt", flash_i.se_cnt, 2);
		compare_value("pp_cnt", flash_i.pp_cnt, 2);
		compare_value("flash err_cnt", flash_i.err_cnt, 0);
		compare_value("early_pp", early_pp, 1'b0);
		// every page holds RAM bytes 8 to 263
		for (p = 0; p < 2; p++) begin
			for (i = 0; i < 256; i++) begin
				a = base + 24'(p * 256 + i);
				compare_value($sformatf("mem[%h]", a), flash_i.mem[a], ram[8 + i]);
			end
		end
	endtask

	initial begin
		int a;
		seed       = 32'he70d_e48a;
		errors     = 0;
		checks     = 0;
		pages_sent = 0;
		rst_n      = 1'b0;
		start      = 1'b0;
		page_ready = 1'b0;
		for (a = 0; a < 512; a++) begin
			ram[a] = 8'($random(seed));
		end
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
		check_reset_values();
		run_status_pickup();
		run_image_update();
		compare_value("sva fail_cnt", flash_ctrl_s25fl_i.flash_ctrl_sva_i.fail_cnt, 0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/flash_cmd_pkg.sv
logic/host_pkg.sv
logic/cmd_ram_reader.sv
logic/flash_sequencer.sv
logic/spi_frame_engine.sv
logic/result_reporter.sv
logic/flash_ctrl_s25fl.sv
tb/spi_flash_model.sv
tb/flash_ctrl_sva.sv
tb/tb_flash_ctrl.sv
